// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_msu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
rtl/msu_pkg.sv
rtl/msu_status_if.sv
rtl/wram_snoop.sv
rtl/msu_databuf.sv
rtl/msu_regs.sv
rtl/msu_readout.sv
rtl/msu_top.sv
verification/msu_assertions.sv
verification/tb_msu.sv

// ==== rtl/msu_databuf.sv ====
`timescale 1ns/1ps

module msu_databuf #(
  parameter int buf_addr_width = msu_pkg::buf_addr_w
) (
  input  logic                      clkin,
  input  logic                      we,
  input  logic [buf_addr_width-1:0] wr_addr,
  input  msu_pkg::byte_t            wr_data,
  input  logic [buf_addr_width-1:0] rd_addr,
  output msu_pkg::byte_t            rd_data
);

  import msu_pkg::*;

  localparam int depth = 1 << buf_addr_width;

  byte_t mem [depth];

  // write port, snooper side
  always_ff @(posedge clkin) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read for block ram inference
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== rtl/msu_pkg.sv ====
package msu_pkg;

  // buffer geometry
  localparam int buf_addr_w = 15;

  typedef logic [buf_addr_w-1:0] buf_addr_t;
  typedef logic [7:0]            byte_t;
  typedef logic [23:0]           snes_addr_t;
  typedef logic [16:0]           wram_offset_t;

  // offsets at or above this are not captured
  localparam int unsigned snoop_limit = 'h7800;

  // host register map, write side
  typedef enum logic [2:0] {
    reg_seek0   = 3'd0,
    reg_seek1   = 3'd1,
    reg_seek2   = 3'd2,
    reg_seek3   = 3'd3,
    reg_track0  = 3'd4,
    reg_track1  = 3'd5,
    reg_volume  = 3'd6,
    reg_control = 3'd7
  } reg_addr_e;

  // read side reuses the same codes
  localparam reg_addr_e reg_status = reg_seek0;
  localparam reg_addr_e reg_data   = reg_seek1;
  localparam reg_addr_e reg_id0    = reg_seek2;
  localparam reg_addr_e reg_id1    = reg_seek3;
  localparam reg_addr_e reg_id2    = reg_track0;
  localparam reg_addr_e reg_id3    = reg_track1;
  localparam reg_addr_e reg_id4    = reg_volume;
  localparam reg_addr_e reg_id5    = reg_control;

  // "S-MSU1", first character in the top byte
  localparam logic [47:0] msu_id       = 48'h53_2D_4D_53_55_31;
  localparam logic [2:0]  msu_revision = 3'd1;

  // b-bus wram port and bank map
  localparam byte_t wram_port_data     = 8'h80;
  localparam byte_t wram_port_addr_lo  = 8'h81;
  localparam byte_t wram_port_addr_mid = 8'h82;
  localparam byte_t wram_port_addr_hi  = 8'h83;
  localparam byte_t wram_bank          = 8'h7E;

endpackage

// ==== rtl/msu_readout.sv ====
`timescale 1ns/1ps

module msu_readout (
  input  logic               clkin,
  input  logic               reset,
  input  logic               enable,
  input  msu_pkg::reg_addr_e reg_addr,
  input  logic               reg_oe_falling,
  input  msu_pkg::byte_t     buf_q,
  output msu_pkg::byte_t     reg_data_out,
  msu_status_if.readout_mp   status
);

  import msu_pkg::*;

  byte_t status_byte;

  // busy flags on top, revision in the low bits
  assign status_byte = {status.data_busy, status.audio_busy, status.audio_status,
                        status.audio_error, msu_revision};

  // latched at the start of the host read cycle
  always_ff @(posedge clkin) begin
    if (reset) begin
      reg_data_out <= '0;
    end else if (reg_oe_falling && enable) begin
      case (reg_addr)
        reg_status: reg_data_out <= status_byte;
        reg_data:   reg_data_out <= buf_q;
        reg_id0:    reg_data_out <= msu_id[47:40];
        reg_id1:    reg_data_out <= msu_id[39:32];
        reg_id2:    reg_data_out <= msu_id[31:24];
        reg_id3:    reg_data_out <= msu_id[23:16];
        reg_id4:    reg_data_out <= msu_id[15:8];
        reg_id5:    reg_data_out <= msu_id[7:0];
      endcase
    end
  end

endmodule

// ==== rtl/msu_regs.sv ====
`timescale 1ns/1ps

module msu_regs #(
  parameter int buf_addr_width = msu_pkg::buf_addr_w
) (
  input  logic                      clkin,
  input  logic                      reset,
  input  logic                      enable,
  input  msu_pkg::reg_addr_e        reg_addr,
  input  msu_pkg::byte_t            reg_data_in,
  input  logic                      reg_oe_rising,
  input  logic                      reg_we_rising,
  input  logic [5:0]                status_reset_bits,
  input  logic [5:0]                status_set_bits,
  input  logic                      status_reset_we,
  input  logic [buf_addr_width-1:0] msu_address_ext,
  input  logic                      msu_address_ext_write,
  output logic [buf_addr_width-1:0] rd_ptr,
  output logic [31:0]               addr_out,
  output logic [15:0]               track_out,
  output msu_pkg::byte_t            volume_out,
  output logic                      volume_latch_out,
  output msu_pkg::byte_t            status_out,
  msu_status_if.regs_mp             status
);

  import msu_pkg::*;

  logic [1:0] reset_we_sr;
  logic [2:0] ext_write_sr;
  logic       status_reset_en;
  logic       ext_write_rising;

  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic       audio_error;
  logic [2:0] audio_ctrl;
  logic [1:0] audio_status;

  // --------------------------------------------------------------------------
  // edge detect on the two level inputs
  // --------------------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      reset_we_sr  <= '0;
      ext_write_sr <= '0;
    end else begin
      reset_we_sr  <= {reset_we_sr[0], status_reset_we};
      ext_write_sr <= {ext_write_sr[1:0], msu_address_ext_write};
    end
  end

  assign status_reset_en  = (reset_we_sr == 2'b01);
  assign ext_write_rising = (ext_write_sr[2:1] == 2'b01);

  // read pointer, auto-increments on each data read
  always_ff @(posedge clkin) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (ext_write_rising) begin
      rd_ptr <= msu_address_ext;
    end else if (reg_oe_rising && enable && (reg_addr == reg_data)) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // host writes and status flag updates
  // --------------------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_out         <= '0;
      track_out        <= '0;
      volume_out       <= '0;
      volume_latch_out <= 1'b0;
      data_start       <= 1'b0;
      data_busy        <= 1'b1;
      audio_start      <= 1'b0;
      audio_busy       <= 1'b1;
      audio_error      <= 1'b0;
      audio_status     <= '0;
      audio_ctrl       <= '0;
      ctrl_start       <= 1'b0;
    end else begin
      volume_latch_out <= 1'b0;
      if (reg_we_rising && enable) begin
        case (reg_addr)
          reg_seek0:  addr_out[7:0]   <= reg_data_in;
          reg_seek1:  addr_out[15:8]  <= reg_data_in;
          reg_seek2:  addr_out[23:16] <= reg_data_in;
          reg_seek3: begin
            addr_out[31:24] <= reg_data_in;
            data_start      <= 1'b1;
            data_busy       <= 1'b1;
          end
          reg_track0: track_out[7:0] <= reg_data_in;
          reg_track1: begin
            track_out[15:8] <= reg_data_in;
            audio_start     <= 1'b1;
            audio_busy      <= 1'b1;
          end
          reg_volume: begin
            volume_out       <= reg_data_in;
            volume_latch_out <= 1'b1;
          end
          reg_control: begin
            // locked while a track is still loading
            if (!audio_busy) begin
              audio_ctrl <= reg_data_in[2:0];
              ctrl_start <= 1'b1;
            end
          end
        endcase
      end else if (status_reset_en) begin
        audio_busy   <= (audio_busy | status_set_bits[5]) & ~status_reset_bits[5];
        data_busy    <= (data_busy | status_set_bits[4]) & ~status_reset_bits[4];
        audio_error  <= (audio_error | status_set_bits[3]) & ~status_reset_bits[3];
        audio_status <= (audio_status | status_set_bits[2:1]) & ~status_reset_bits[2:1];
        ctrl_start   <= (ctrl_start | status_set_bits[0]) & ~status_reset_bits[0];
        if (status_reset_bits[5]) begin
          audio_start <= 1'b0;
        end
        if (status_reset_bits[4]) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  assign status_out = {rd_ptr[13], audio_start, data_start, volume_latch_out,
                       audio_ctrl, ctrl_start};

  assign status.data_busy    = data_busy;
  assign status.audio_busy   = audio_busy;
  assign status.audio_status = audio_status;
  assign status.audio_error  = audio_error;

endmodule

// ==== rtl/msu_status_if.sv ====
`timescale 1ns/1ps

interface msu_status_if;

  logic       data_busy;
  logic       audio_busy;
  logic [1:0] audio_status;
  logic       audio_error;

  // register block owns the flags
  modport regs_mp (
    output data_busy, audio_busy, audio_status, audio_error
  );

  // readout only samples them for the status byte
  modport readout_mp (
    input data_busy, audio_busy, audio_status, audio_error
  );

endinterface

// ==== rtl/msu_top.sv ====
`timescale 1ns/1ps

module msu_top #(
  parameter int          buf_addr_width = msu_pkg::buf_addr_w,
  parameter int unsigned snoop_limit    = msu_pkg::snoop_limit
) (
  input  logic                clkin,
  input  logic                reset,
  input  logic                enable,

  // host register bus
  input  msu_pkg::reg_addr_e  reg_addr,
  input  msu_pkg::byte_t      reg_data_in,
  input  logic                reg_oe_falling,
  input  logic                reg_oe_rising,
  input  logic                reg_we_rising,
  output msu_pkg::byte_t      reg_data_out,

  // host controller side
  input  logic [5:0]          status_reset_bits,
  input  logic [5:0]          status_set_bits,
  input  logic                status_reset_we,
  input  msu_pkg::buf_addr_t  msu_address_ext,
  input  logic                msu_address_ext_write,
  output msu_pkg::byte_t      status_out,
  output msu_pkg::byte_t      volume_out,
  output logic                volume_latch_out,
  output logic [31:0]         addr_out,
  output logic [15:0]         track_out,
  output msu_pkg::byte_t      msu_data_out,

  // console bus snoop
  input  logic                snes_wr_end,
  input  logic                snes_pard_end,
  input  logic                snes_pawr_end,
  input  msu_pkg::snes_addr_t snes_addr,
  input  msu_pkg::byte_t      snes_pa,
  input  msu_pkg::byte_t      snes_data
);

  import msu_pkg::*;

  logic                      snoop_we;
  logic [buf_addr_width-1:0] snoop_addr;
  byte_t                     snoop_data;
  logic [buf_addr_width-1:0] rd_ptr;
  byte_t                     buf_q;

  msu_status_if status_if ();

  // --------------------------------------------------------------------------
  // input side
  // --------------------------------------------------------------------------
  wram_snoop #(
    .buf_addr_width (buf_addr_width),
    .snoop_limit    (snoop_limit)
  ) wram_snoop_inst (
    .clkin         (clkin),
    .reset         (reset),
    .snes_wr_end   (snes_wr_end),
    .snes_pard_end (snes_pard_end),
    .snes_pawr_end (snes_pawr_end),
    .snes_addr     (snes_addr),
    .snes_pa       (snes_pa),
    .snes_data     (snes_data),
    .snoop_we      (snoop_we),
    .snoop_addr    (snoop_addr),
    .snoop_data    (snoop_data)
  );

  // --------------------------------------------------------------------------
  // buffer and registers
  // --------------------------------------------------------------------------
  msu_databuf #(
    .buf_addr_width (buf_addr_width)
  ) msu_databuf_inst (
    .clkin   (clkin),
    .we      (snoop_we),
    .wr_addr (snoop_addr),
    .wr_data (snoop_data),
    .rd_addr (rd_ptr),
    .rd_data (buf_q)
  );

  msu_regs #(
    .buf_addr_width (buf_addr_width)
  ) msu_regs_inst (
    .clkin                 (clkin),
    .reset                 (reset),
    .enable                (enable),
    .reg_addr              (reg_addr),
    .reg_data_in           (reg_data_in),
    .reg_oe_rising         (reg_oe_rising),
    .reg_we_rising         (reg_we_rising),
    .status_reset_bits     (status_reset_bits),
    .status_set_bits       (status_set_bits),
    .status_reset_we       (status_reset_we),
    .msu_address_ext       (msu_address_ext),
    .msu_address_ext_write (msu_address_ext_write),
    .rd_ptr                (rd_ptr),
    .addr_out              (addr_out),
    .track_out             (track_out),
    .volume_out            (volume_out),
    .volume_latch_out      (volume_latch_out),
    .status_out            (status_out),
    .status                (status_if.regs_mp)
  );

  // output side
  msu_readout msu_readout_inst (
    .clkin          (clkin),
    .reset          (reset),
    .enable         (enable),
    .reg_addr       (reg_addr),
    .reg_oe_falling (reg_oe_falling),
    .buf_q          (buf_q),
    .reg_data_out   (reg_data_out),
    .status         (status_if.readout_mp)
  );

  assign msu_data_out = buf_q;

endmodule

// ==== rtl/wram_snoop.sv ====
`timescale 1ns/1ps

module wram_snoop #(
  parameter int          buf_addr_width = msu_pkg::buf_addr_w,
  parameter int unsigned snoop_limit    = msu_pkg::snoop_limit
) (
  input  logic                      clkin,
  input  logic                      reset,
  input  logic                      snes_wr_end,
  input  logic                      snes_pard_end,
  input  logic                      snes_pawr_end,
  input  msu_pkg::snes_addr_t       snes_addr,
  input  msu_pkg::byte_t            snes_pa,
  input  msu_pkg::byte_t            snes_data,
  output logic                      snoop_we,
  output logic [buf_addr_width-1:0] snoop_addr,
  output msu_pkg::byte_t            snoop_data
);

  import msu_pkg::*;

  byte_t        snes_data_r;
  wram_offset_t port_addr;
  wram_offset_t wram_offset;
  logic         shadow_hit;
  logic         bank_hit;
  logic         port_hit;
  logic         shadow_r;
  logic         bank_r;
  logic         port_r;
  logic         wram_write;

  // --------------------------------------------------------------------------
  // address decode, one cycle ahead of the end strobe
  // --------------------------------------------------------------------------
  // low 8k mirror in banks 00-3f and 80-bf
  assign shadow_hit = !snes_addr[22] && (snes_addr[15:13] == 3'h0);
  assign bank_hit   = ({snes_addr[23:17], 1'b0} == wram_bank);
  assign port_hit   = (snes_pa == wram_port_data);

  always_ff @(posedge clkin) begin
    snes_data_r <= snes_data;
    if (reset) begin
      shadow_r <= 1'b0;
      bank_r   <= 1'b0;
      port_r   <= 1'b0;
    end else begin
      shadow_r <= shadow_hit;
      bank_r   <= bank_hit;
      port_r   <= port_hit;
    end
  end

  // wram data port address, advances on every access to 2180
  always_ff @(posedge clkin) begin
    if (reset) begin
      port_addr <= '0;
    end else begin
      if ((snes_pawr_end || snes_pard_end) && (snes_pa == wram_port_data)) begin
        port_addr <= port_addr + 1'b1;
      end
      if (snes_pawr_end) begin
        if (snes_pa == wram_port_addr_lo) begin
          port_addr[7:0] <= snes_data_r;
        end else if (snes_pa == wram_port_addr_mid) begin
          port_addr[15:8] <= snes_data_r;
        end else if (snes_pa == wram_port_addr_hi) begin
          port_addr[16] <= snes_data_r[0];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // capture into the buffer
  // --------------------------------------------------------------------------
  assign wram_offset = shadow_hit ? {4'b0000, snes_addr[12:0]} :
                       bank_hit   ? snes_addr[16:0] :
                                    port_addr;

  assign wram_write = (snes_wr_end && (shadow_r || bank_r)) || (snes_pawr_end && port_r);

  always_ff @(posedge clkin) begin
    snoop_addr <= wram_offset[buf_addr_width-1:0];
    snoop_data <= snes_data_r;
    if (reset) begin
      snoop_we <= 1'b0;
    end else begin
      snoop_we <= wram_write && (wram_offset < snoop_limit);
    end
  end

endmodule

// ==== verification/msu_assertions.sv ====
`timescale 1ns/1ps

module msu_assertions (
  input logic               clkin,
  input logic               reset,
  input logic               enable,
  input msu_pkg::reg_addr_e reg_addr,
  input msu_pkg::byte_t     reg_data_in,
  input logic               reg_we_rising,
  input logic               reg_oe_falling,
  input logic [31:0]        addr_out,
  input logic [15:0]        track_out,
  input msu_pkg::byte_t     volume_out,
  input logic               volume_latch_out,
  input msu_pkg::byte_t     status_out,
  input msu_pkg::byte_t     reg_data_out
);

  import msu_pkg::*;

  logic seek0_write;
  logic seek3_write;
  logic track1_write;
  logic volume_write;
  logic read_latch;

  // one sticky flag per property, the testbench watches the OR
  logic seek_low_fail  = 1'b0;
  logic seek_high_fail = 1'b0;
  logic track_fail     = 1'b0;
  logic volume_fail    = 1'b0;
  logic latch_fail     = 1'b0;
  logic hold_fail      = 1'b0;
  logic assertion_failed;

  assign seek0_write  = reg_we_rising && enable && (reg_addr == reg_seek0);
  assign seek3_write  = reg_we_rising && enable && (reg_addr == reg_seek3);
  assign track1_write = reg_we_rising && enable && (reg_addr == reg_track1);
  assign volume_write = reg_we_rising && enable && (reg_addr == reg_volume);
  assign read_latch   = reg_oe_falling && enable;

  assign assertion_failed = seek_low_fail | seek_high_fail | track_fail |
                            volume_fail | latch_fail | hold_fail;

  // --------------------------------------------------------------------------
  // host writes land on the next edge
  // --------------------------------------------------------------------------
  seek_low_byte: assert property (@(posedge clkin) disable iff (reset)
    seek0_write |=> (addr_out[7:0] == $past(reg_data_in)))
    else begin
      seek_low_fail <= 1'b1;
      $error("seek byte 0 missing from addr_out after the write");
    end

  // top seek byte also kicks off the data load
  seek_high_start: assert property (@(posedge clkin) disable iff (reset)
    seek3_write |=> ((addr_out[31:24] == $past(reg_data_in)) && status_out[5]))
    else begin
      seek_high_fail <= 1'b1;
      $error("seek byte 3 write did not update addr_out and data_start");
    end

  track_high_start: assert property (@(posedge clkin) disable iff (reset)
    track1_write |=> ((track_out[15:8] == $past(reg_data_in)) && status_out[6]))
    else begin
      track_fail <= 1'b1;
      $error("track byte 1 write did not update track_out and audio_start");
    end

  volume_update: assert property (@(posedge clkin) disable iff (reset)
    volume_write |=> (volume_latch_out && (volume_out == $past(reg_data_in))))
    else begin
      volume_fail <= 1'b1;
      $error("volume write did not update volume_out with the latch strobe");
    end

  // latch strobe only ever follows a volume write
  volume_latch_single: assert property (@(posedge clkin) disable iff (reset)
    volume_latch_out |-> $past(volume_write))
    else begin
      latch_fail <= 1'b1;
      $error("volume_latch_out high without a volume write one edge before");
    end

  // --------------------------------------------------------------------------
  // read data register
  // --------------------------------------------------------------------------
  read_data_hold: assert property (@(posedge clkin) disable iff (reset)
    !read_latch |=> $stable(reg_data_out))
    else begin
      hold_fail <= 1'b1;
      $error("reg_data_out changed without a read strobe");
    end

endmodule

// ==== verification/tb_msu.sv ====
`timescale 1ns/1ps

module tb_msu;

  import msu_pkg::*;

  localparam int          num_tests       = 5;
  localparam int          watchdog_cycles = num_tests * 200 + 100;
  // low enough that the 8k shadow window can cross it
  localparam int unsigned capture_limit   = 'h1800;
  localparam snes_addr_t  idle_addr       = 24'h40_8000;

  logic         clkin;
  logic         reset;
  logic         enable;
  reg_addr_e    reg_addr;
  byte_t        reg_data_in;
  logic         reg_oe_falling;
  logic         reg_oe_rising;
  logic         reg_we_rising;
  byte_t        reg_data_out;
  logic [5:0]   status_reset_bits;
  logic [5:0]   status_set_bits;
  logic         status_reset_we;
  buf_addr_t    msu_address_ext;
  logic         msu_address_ext_write;
  byte_t        status_out;
  byte_t        volume_out;
  logic         volume_latch_out;
  logic [31:0]  addr_out;
  logic [15:0]  track_out;
  byte_t        msu_data_out;
  logic         snes_wr_end;
  logic         snes_pard_end;
  logic         snes_pawr_end;
  snes_addr_t   snes_addr;
  byte_t        snes_pa;
  byte_t        snes_data;

  // expected buffer contents, keyed by buffer index
  byte_t        model [buf_addr_t];
  wram_offset_t port_offset;

  msu_top #(
    .buf_addr_width (buf_addr_w),
    .snoop_limit    (capture_limit)
  ) msu_top_inst (.*);

  bind msu_top msu_assertions msu_assertions_inst (.*);

  initial begin
    clkin = 1'b0;
    forever begin
      #4 clkin = ~clkin;
    end
  end

  // --------------------------------------------------------------------------
  // reporting and checks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_failure(input string text);
    $display("%s", text);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
      else report_mismatch(name, got, exp);
  endtask

  // --------------------------------------------------------------------------
  // bus drivers
  // --------------------------------------------------------------------------
  task automatic step();
    @(posedge clkin);
    #1;
  endtask

  task automatic write_reg(input reg_addr_e a, input byte_t d);
    reg_addr      = a;
    reg_data_in   = d;
    reg_we_rising = 1'b1;
    step();
    reg_we_rising = 1'b0;
  endtask

  // falling strobe latches, rising strobe advances, then one idle edge for buf_q
  task automatic read_reg(input reg_addr_e a, output byte_t d);
    reg_addr       = a;
    reg_oe_falling = 1'b1;
    step();
    reg_oe_falling = 1'b0;
    d              = reg_data_out;
    reg_oe_rising  = 1'b1;
    step();
    reg_oe_rising  = 1'b0;
    step();
  endtask

  task automatic pulse_status_reset(input logic [5:0] bits);
    status_reset_bits = bits;
    status_reset_we   = 1'b1;
    repeat (3) step();
    status_reset_we   = 1'b0;
    step();
  endtask

  task automatic load_read_pointer(input buf_addr_t p);
    msu_address_ext       = p;
    msu_address_ext_write = 1'b1;
    repeat (4) step();
    msu_address_ext_write = 1'b0;
    step();
  endtask

  // address and data one cycle ahead of the end strobe
  task automatic bus_write(input logic via_port, input snes_addr_t a, input byte_t pa,
                           input byte_t d, input logic expect_store);
    snes_addr = a;
    snes_pa   = pa;
    snes_data = d;
    step();
    snes_wr_end   = !via_port;
    snes_pawr_end = via_port;
    step();
    snes_wr_end   = 1'b0;
    snes_pawr_end = 1'b0;
    check_value("snoop_we", 32'(msu_top_inst.snoop_we), 32'(expect_store));
    snes_addr = idle_addr;
    snes_pa   = 8'h00;
    step();
  endtask

  task automatic wram_write(input logic via_port, input snes_addr_t a,
                            input wram_offset_t off, input byte_t d);
    logic stored;
    stored = (32'(off) < capture_limit);
    bus_write(via_port, a, via_port ? wram_port_data : 8'h00, d, stored);
    if (stored) begin
      model[buf_addr_t'(off)] = d;
    end
  endtask

  task automatic port_load(input wram_offset_t off);
    bus_write(1'b1, idle_addr, wram_port_addr_lo, off[7:0], 1'b0);
    bus_write(1'b1, idle_addr, wram_port_addr_mid, off[15:8], 1'b0);
    bus_write(1'b1, idle_addr, wram_port_addr_hi, {7'b0000000, off[16]}, 1'b0);
    port_offset = off;
  endtask

  task automatic port_data_write(input byte_t d);
    wram_write(1'b1, idle_addr, port_offset, d);
    port_offset = port_offset + 17'd1;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0]  seek_val;
    logic [15:0]  track_val;
    byte_t        vol;
    byte_t        ctl;
    byte_t        got;
    wram_offset_t base;
    wram_offset_t off;
    buf_addr_t    idx;
    byte_t        id_bytes [6] = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};
    reg_addr_e    id_regs [6]  = '{reg_id0, reg_id1, reg_id2, reg_id3, reg_id4, reg_id5};

    void'($urandom(32'hc44bf6be));
    reset                 = 1'b1;
    enable                = 1'b0;
    reg_addr              = reg_seek0;
    reg_data_in           = 8'h00;
    reg_oe_falling        = 1'b0;
    reg_oe_rising         = 1'b0;
    reg_we_rising         = 1'b0;
    status_reset_bits     = 6'd0;
    status_set_bits       = 6'd0;
    status_reset_we       = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    snes_wr_end           = 1'b0;
    snes_pard_end         = 1'b0;
    snes_pawr_end         = 1'b0;
    snes_addr             = idle_addr;
    snes_pa               = 8'h00;
    snes_data             = 8'h00;
    port_offset           = '0;
    repeat (5) step();
    reset  = 1'b0;
    enable = 1'b1;
    step();

    // after reset, both busy and revision 1
    check_value("status_out", 32'(status_out), 32'd0);
    check_value("volume_latch_out", 32'(volume_latch_out), 32'd0);
    read_reg(reg_status, got);
    check_value("status byte", 32'(got), 32'({1'b1, 1'b1, 2'b00, 1'b0, 3'd1}));

    // seek, track, volume
    seek_val  = $urandom;
    track_val = 16'($urandom);
    write_reg(reg_seek0, seek_val[7:0]);
    write_reg(reg_seek1, seek_val[15:8]);
    write_reg(reg_seek2, seek_val[23:16]);
    write_reg(reg_seek3, seek_val[31:24]);
    write_reg(reg_track0, track_val[7:0]);
    write_reg(reg_track1, track_val[15:8]);
    check_value("addr_out", addr_out, seek_val);
    check_value("track_out", 32'(track_out), 32'(track_val));
    check_value("status_out[6:5]", 32'(status_out[6:5]), 32'd3);
    vol = byte_t'($urandom);
    write_reg(reg_volume, vol);
    check_value("volume_out", 32'(volume_out), 32'(vol));
    check_value("volume_latch_out", 32'(volume_latch_out), 32'd1);
    step();
    check_value("volume_latch_out", 32'(volume_latch_out), 32'd0);

    for (int i = 0; i < 6; i++) begin
      read_reg(id_regs[i], got);
      check_value("identifier byte", 32'(got), 32'(id_bytes[i]));
    end

    // clear both busy flags, then the control register
    pulse_status_reset(6'b110000);
    check_value("status_out[6:5]", 32'(status_out[6:5]), 32'd0);
    read_reg(reg_status, got);
    check_value("status byte", 32'(got), 32'({1'b0, 1'b0, 2'b00, 1'b0, 3'd1}));
    ctl = byte_t'($urandom);
    write_reg(reg_control, ctl);
    check_value("status_out[3:0]", 32'(status_out[3:0]), 32'({ctl[2:0], 1'b1}));
    write_reg(reg_track1, track_val[15:8]);
    write_reg(reg_control, ~ctl);
    check_value("status_out[3:0]", 32'(status_out[3:0]), 32'({ctl[2:0], 1'b1}));

    // wram snoop, below the limit on every path
    base = wram_offset_t'(32'h100 + ($urandom % 32'hf00));
    for (int i = 0; i < 4; i++) begin
      off = base + wram_offset_t'(i);
      wram_write(1'b0, {7'b0111111, off}, off, byte_t'($urandom));
    end
    for (int i = 4; i < 8; i++) begin
      off = base + wram_offset_t'(i);
      wram_write(1'b0, {11'h000, off[12:0]}, off, byte_t'($urandom));
    end
    port_load(base + 17'd8);
    for (int i = 0; i < 4; i++) begin
      port_data_write(byte_t'($urandom));
    end

    // at or above the limit, some aliasing onto stored bytes
    off = base + 17'h08000;
    wram_write(1'b0, {7'b0111111, off}, off, byte_t'($urandom));
    off = base + 17'h10001;
    wram_write(1'b0, {7'b0111111, off}, off, byte_t'($urandom));
    off = 17'h01800 + wram_offset_t'($urandom % 32'h800);
    wram_write(1'b0, {11'h000, off[12:0]}, off, byte_t'($urandom));
    port_load(base + 17'h10008);
    port_data_write(byte_t'($urandom));

    load_read_pointer(buf_addr_t'(base));
    check_value("msu_data_out", 32'(msu_data_out), 32'(model[buf_addr_t'(base)]));
    for (int i = 0; i < 12; i++) begin
      idx = buf_addr_t'(base) + buf_addr_t'(i);
      read_reg(reg_data, got);
      check_value("reg_data_out", 32'(got), 32'(model[idx]));
    end

    step();
    if (msu_top_inst.msu_assertions_inst.assertion_failed) begin
      report_failure("a register timing assertion fired");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

  always @(posedge clkin) begin
    if (msu_top_inst.msu_assertions_inst.assertion_failed) begin
      report_failure("a register timing assertion fired");
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clkin);
    report_failure("watchdog expired before the test sequence finished");
  end

endmodule
